/* cache_array_pkg.sv */
/* array side types
   tag and data array ports and the bus carried between pipe stages */
`include "cache_config.svh"

package cache_array_pkg;

  typedef logic [`CACHE_TAG_W-1:0]    tag_t;
  typedef logic [`CACHE_SET_W-1:0]    set_t;
  typedef logic [`CACHE_WAY_W-1:0]    way_t;
  typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
  typedef logic [`CACHE_NUM_WAYS-1:0] way_vec_t;  // one bit per way
  typedef logic [`CACHE_NUM_WAYS-1:0][`CACHE_TAG_W-1:0] way_tags_t;

  typedef struct packed {
    way_tags_t tags;
    way_vec_t  valid;
    way_vec_t  mru;
    way_vec_t  modified;
  } set_rd_rsp_t;

  typedef struct packed {
    logic        en;
    set_t        set;
    set_rd_rsp_t payload;  // full new state of the set
  } set_wr_req_t;

  typedef struct packed {
    set_t set;
    way_t way;
  } cl_addr_t;

  typedef struct packed {
    logic                   en;
    cl_addr_t               cl_addr;
    cache_lu_pkg::cl_data_t data;
  } cl_wr_req_t;

  typedef struct packed {
    logic                   valid;
    cache_lu_pkg::lu_op_t   lu_op;
    cache_lu_pkg::tq_id_t   tq_id;
    tag_t                   tag;
    set_t                   set;
    offset_t                offset;
    cache_lu_pkg::word_t    data;
    cache_lu_pkg::cl_data_t cl_data;
    logic                   fill_modified;
    // filled in at q2
    logic                   hit;
    logic                   miss;
    way_vec_t               hit_way;     // one-hot
    way_vec_t               victim_way;  // one-hot, fill only
    cl_addr_t               cl_addr;
    logic                   dirty_evict;
    tag_t                   victim_tag;
  } pipe_bus_t;

endpackage

/* cache_config.svh */
/* cache geometry
   sizes of the 4-way cache and the bit positions of the address fields */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// ==============================
// ways and sets
// ==============================
`define CACHE_NUM_WAYS     4
`define CACHE_WAY_W        2
`define CACHE_NUM_SETS     16
`define CACHE_SET_W        4
`define CACHE_NUM_LINES    (`CACHE_NUM_SETS * `CACHE_NUM_WAYS) // data array depth

// ==============================
// line and address layout
// ==============================
`define CACHE_WORDS_IN_CL  4
`define CACHE_WORD_W       32
`define CACHE_ADDR_W       20
`define CACHE_OFFSET_W     4    // byte offset, bits 3..0
`define CACHE_WORD_OFF_LSB 2    // word select is offset bits 3..2
`define CACHE_WORD_OFF_W   2
`define CACHE_SET_LSB      4    // set at bits 7..4
`define CACHE_TAG_LSB      8    // tag at bits 19..8
`define CACHE_TAG_W        12
`define CACHE_TQ_ID_W      4

`endif

/* cache_data_array.sv */
/* cache data array
   one line per set and way, registered read with write forwarding */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_data_array (
  input  logic                        clk,
  input  cache_array_pkg::cl_addr_t   rd_addr,
  output cache_lu_pkg::cl_data_t      rd_data,
  input  cache_array_pkg::cl_wr_req_t wr_req
);

  localparam int IDX_W = `CACHE_SET_W + `CACHE_WAY_W;

  cache_lu_pkg::cl_data_t mem [`CACHE_NUM_LINES]; // indexed by {set, way}
  logic [IDX_W-1:0]       rd_idx;
  logic [IDX_W-1:0]       wr_idx;

  assign rd_idx = {rd_addr.set, rd_addr.way};
  assign wr_idx = {wr_req.cl_addr.set, wr_req.cl_addr.way};

  // ==============================
  // write port, q3
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_req.en) begin
      mem[wr_idx] <= wr_req.data;
    end
  end

  // ==============================
  // read port, q2 address in, q3 data out
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_req.en && (wr_idx == rd_idx)) begin
      rd_data <= wr_req.data;   // line being written this edge
    end else begin
      rd_data <= mem[rd_idx];
    end
  end

endmodule

/* cache_lu_pkg.sv */
/* lookup side types
   requests and responses of the lookup port and the far-memory strobe */
`include "cache_config.svh"

package cache_lu_pkg;

  typedef logic [`CACHE_ADDR_W-1:0]  addr_t;
  typedef logic [`CACHE_TQ_ID_W-1:0] tq_id_t;
  typedef logic [`CACHE_WORD_W-1:0]  word_t;
  typedef logic [`CACHE_WORDS_IN_CL-1:0][`CACHE_WORD_W-1:0] cl_data_t; // one line

  typedef enum logic [1:0] {lu_rd, lu_wr, lu_fill} lu_op_t;
  typedef enum logic [1:0] {res_no_rsp, res_hit, res_miss} lu_result_t;
  typedef enum logic {fm_fill_req, fm_dirty_evict} fm_op_t;

  typedef struct packed {
    logic     valid;
    lu_op_t   lu_op;
    tq_id_t   tq_id;
    addr_t    address;
    word_t    data;          // write word
    cl_data_t cl_data;       // fill line
    logic     fill_modified; // fill line already dirty
  } lu_req_t;

  typedef struct packed {
    logic       valid;
    lu_op_t     lu_op;
    lu_result_t result;
    tq_id_t     tq_id;
    addr_t      address;
    cl_data_t   data;
  } lu_rsp_t;

  typedef struct packed {
    logic     valid;
    fm_op_t   opcode;
    tq_id_t   tq_id;
    addr_t    address;
    cl_data_t data;  // evicted line, zero on fill request
  } fm_req_t;

endpackage

/* cache_pipe.sv */
/* cache lookup pipeline, top level
   q1 address split, q2 tag compare and set update, q3 response
   fixed two-cycle latency, no back-pressure */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_pipe (
  input  logic                  clk,
  input  logic                  rst,
  input  cache_lu_pkg::lu_req_t lu_req,
  output cache_lu_pkg::lu_rsp_t lu_rsp,
  output cache_lu_pkg::fm_req_t fm_req
);

  cache_array_pkg::pipe_bus_t   bus_q1;
  cache_array_pkg::pipe_bus_t   bus_q2_in;   // q2 register, before tag stage
  cache_array_pkg::pipe_bus_t   bus_q2;      // q2 with compare results
  cache_array_pkg::pipe_bus_t   bus_q3;
  logic [`CACHE_SET_W-1:0]      set_rd_set;
  cache_array_pkg::set_rd_rsp_t set_rd_rsp;
  cache_array_pkg::set_wr_req_t set_wr_req;
  cache_array_pkg::cl_addr_t    cl_rd_addr;
  cache_lu_pkg::cl_data_t       cl_rd_data;
  cache_array_pkg::cl_wr_req_t  cl_wr_req;

  // ==============================
  // q1 address split
  // ==============================
  always_comb begin
    bus_q1               = '0;                     // q2 results start clear
    bus_q1.valid         = lu_req.valid;
    bus_q1.lu_op         = lu_req.lu_op;
    bus_q1.tq_id         = lu_req.tq_id;
    bus_q1.tag           = lu_req.address[`CACHE_TAG_LSB +: `CACHE_TAG_W];
    bus_q1.set           = lu_req.address[`CACHE_SET_LSB +: `CACHE_SET_W];
    bus_q1.offset        = lu_req.address[`CACHE_OFFSET_W-1:0];
    bus_q1.data          = lu_req.data;
    bus_q1.cl_data       = lu_req.cl_data;
    bus_q1.fill_modified = lu_req.fill_modified;
  end

  assign set_rd_set = bus_q1.set;  // tag read starts at q1

  // pipe registers, only valid is reset
  always_ff @(posedge clk) begin
    bus_q2_in <= bus_q1;
    bus_q3    <= bus_q2;
    if (rst) begin
      bus_q2_in.valid <= 1'b0;
      bus_q3.valid    <= 1'b0;
    end
  end

  cache_tag_array i_tag_array (
    .clk    (clk),
    .rst    (rst),
    .rd_set (set_rd_set),
    .rd_rsp (set_rd_rsp),
    .wr_req (set_wr_req)
  );

  cache_tag_stage i_tag_stage (
    .bus_in     (bus_q2_in),
    .set_rsp    (set_rd_rsp),
    .bus_out    (bus_q2),
    .set_wr     (set_wr_req),
    .cl_rd_addr (cl_rd_addr)
  );

  cache_data_array i_data_array (
    .clk     (clk),
    .rd_addr (cl_rd_addr),
    .rd_data (cl_rd_data),
    .wr_req  (cl_wr_req)
  );

  cache_rsp_stage i_rsp_stage (
    .bus_in     (bus_q3),
    .cl_rd_data (cl_rd_data),
    .lu_rsp     (lu_rsp),
    .fm_req     (fm_req),
    .cl_wr_req  (cl_wr_req)
  );

endmodule

/* cache_pipe_assert.sv */
/* cache pipe assertions
   response result, q2 victim encoding and far-memory strobe timing */
`timescale 1ns/1ps

module cache_pipe_assert (
  input logic                      clk,
  input logic                      rst,
  input cache_lu_pkg::lu_rsp_t     lu_rsp,
  input cache_lu_pkg::fm_req_t     fm_req,
  input cache_array_pkg::way_vec_t victim_way  // q2 victim, one-hot
);

  // a valid response is always a hit or a miss
  rsp_has_result: assert property (@(posedge clk) disable iff (rst)
    lu_rsp.valid |-> (lu_rsp.result != cache_lu_pkg::res_no_rsp))
    else $error("lookup response valid with no result");

  // at most one victim way
  victim_onehot0: assert property (@(posedge clk) disable iff (rst)
    $onehot0(victim_way))
    else $error("q2 victim way has more than one bit set");

  // far memory strobe only rides along with a response
  fm_with_rsp: assert property (@(posedge clk) disable iff (rst)
    fm_req.valid |-> lu_rsp.valid)
    else $error("far-memory request without a lookup response");

endmodule

bind cache_pipe cache_pipe_assert i_cache_pipe_assert (
  .clk        (clk),
  .rst        (rst),
  .lu_rsp     (lu_rsp),
  .fm_req     (fm_req),
  .victim_way (bus_q2.victim_way)
);

/* cache_pipe_tb.sv */
/* cache pipe testbench
   directed lookups against a model of tags, state bits and lines,
   responses and far-memory strobes checked in issue order */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_pipe_tb;

  logic                  clk;
  logic                  rst;
  cache_lu_pkg::lu_req_t lu_req;
  cache_lu_pkg::lu_rsp_t lu_rsp;
  cache_lu_pkg::fm_req_t fm_req;
  integer                seed;
  logic [`CACHE_TQ_ID_W-1:0] tq_cnt;

  // ==============================
  // reference model state
  // ==============================
  logic [`CACHE_TAG_W-1:0]    m_tag   [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
  logic [`CACHE_NUM_WAYS-1:0] m_valid [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_WAYS-1:0] m_mru   [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_WAYS-1:0] m_mod   [`CACHE_NUM_SETS];
  cache_lu_pkg::cl_data_t     m_line  [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];

  cache_lu_pkg::lu_rsp_t     exp_rsp [$];  // expected responses, issue order
  cache_lu_pkg::fm_req_t     exp_fm  [$];
  cache_array_pkg::way_vec_t exp_vic [$];  // victim seen at q3

  cache_pipe i_cache_pipe (
    .clk    (clk),
    .rst    (rst),
    .lu_req (lu_req),
    .lu_rsp (lu_rsp),
    .fm_req (fm_req)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout: %s", what);
    $display("Simulation failed");
    $fatal(1, "wait timed out");
  endtask

  function automatic cache_lu_pkg::cl_data_t rand_line();
    cache_lu_pkg::cl_data_t line;
    for (int i = 0; i < `CACHE_WORDS_IN_CL; i++) line[i] = $random(seed);
    return line;
  endfunction

  // mark way as newest, clear the others once every way is mru
  task automatic touch(input int set, input int way);
    m_mru[set][way] = 1'b1;
    if (&m_mru[set]) m_mru[set] = 1 << way;
  endtask

  task automatic predict(input cache_lu_pkg::lu_req_t req);
    cache_lu_pkg::lu_rsp_t     rsp;
    cache_lu_pkg::fm_req_t     fm;
    cache_array_pkg::way_vec_t vic;
    logic [`CACHE_TAG_W-1:0]   tag;
    int                        set;
    int                        wo;
    int                        hw;
    int                        vw;
    tag = req.address[`CACHE_TAG_LSB +: `CACHE_TAG_W];
    set = req.address[`CACHE_SET_LSB +: `CACHE_SET_W];
    wo  = req.address[`CACHE_WORD_OFF_LSB +: `CACHE_WORD_OFF_W];
    hw  = -1;
    vw  = -1;
    vic = '0;
    fm  = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (m_valid[set][w] && (m_tag[set][w] == tag)) hw = w;
    end
    rsp         = '0;
    rsp.valid   = 1'b1;
    rsp.lu_op   = req.lu_op;
    rsp.tq_id   = req.tq_id;
    rsp.address = req.address;
    rsp.result  = (hw >= 0) ? cache_lu_pkg::res_hit : cache_lu_pkg::res_miss;
    if (req.lu_op != cache_lu_pkg::lu_fill && hw < 0) begin  // rd or wr miss
      fm.valid   = 1'b1;
      fm.opcode  = cache_lu_pkg::fm_fill_req;
      fm.tq_id   = req.tq_id;
      fm.address = req.address;
    end else if (req.lu_op == cache_lu_pkg::lu_rd) begin
      rsp.data = m_line[set][hw];
      touch(set, hw);
    end else if (req.lu_op == cache_lu_pkg::lu_wr) begin
      m_line[set][hw][wo] = req.data;                        // word merge
      m_mod[set][hw]      = 1'b1;
      touch(set, hw);
    end else begin
      for (int w = `CACHE_NUM_WAYS-1; w >= 0; w--) if (!m_mru[set][w]) vw = w;
      for (int w = `CACHE_NUM_WAYS-1; w >= 0; w--) if (!m_valid[set][w]) vw = w; // free first
      vic[vw] = 1'b1;
      if (m_valid[set][vw] && m_mod[set][vw]) begin
        fm.valid   = 1'b1;
        fm.opcode  = cache_lu_pkg::fm_dirty_evict;
        fm.tq_id   = req.tq_id;
        fm.address = {m_tag[set][vw], 4'(set), {`CACHE_OFFSET_W{1'b0}}};
        fm.data    = m_line[set][vw];
      end
      m_tag[set][vw]   = tag;
      m_valid[set][vw] = 1'b1;
      m_mod[set][vw]   = req.fill_modified;
      m_line[set][vw]  = req.cl_data;
      rsp.data         = req.cl_data;
      touch(set, vw);
    end
    exp_rsp.push_back(rsp);
    exp_fm.push_back(fm);
    exp_vic.push_back(vic);
  endtask

  // ==============================
  // drive and collect
  // ==============================
  task automatic issue(input cache_lu_pkg::lu_op_t op, input cache_lu_pkg::addr_t addr,
                       input cache_lu_pkg::word_t word, input cache_lu_pkg::cl_data_t line,
                       input logic fmod);
    cache_lu_pkg::lu_req_t req;
    req               = '0;
    req.valid         = 1'b1;
    req.lu_op         = op;
    req.tq_id         = tq_cnt;
    req.address       = addr;
    req.data          = word;
    req.cl_data       = line;
    req.fill_modified = fmod;
    tq_cnt            = tq_cnt + 1'b1;
    @(posedge clk);
    lu_req <= req;
    predict(req);
  endtask

  task automatic idle();
    @(posedge clk);
    lu_req <= '0;
  endtask

  // one response per negedge, oldest expectation first
  task automatic drain();
    cache_lu_pkg::lu_rsp_t     e_rsp;
    cache_lu_pkg::fm_req_t     e_fm;
    cache_array_pkg::way_vec_t e_vic;
    int                        waited;
    while (exp_rsp.size() > 0) begin
      waited = 0;
      @(negedge clk);
      while (lu_rsp.valid !== 1'b1) begin
        if (waited >= 10) timeout_fail("no lookup response within 10 cycles");
        @(negedge clk);
        waited++;
      end
      e_rsp = exp_rsp.pop_front();
      e_fm  = exp_fm.pop_front();
      e_vic = exp_vic.pop_front();
      check_eq("lu_rsp.lu_op", lu_rsp.lu_op, e_rsp.lu_op);
      check_eq("lu_rsp.result", lu_rsp.result, e_rsp.result);
      check_eq("lu_rsp.tq_id", lu_rsp.tq_id, e_rsp.tq_id);
      check_eq("lu_rsp.address", lu_rsp.address, e_rsp.address);
      check_eq("lu_rsp.data", lu_rsp.data, e_rsp.data);
      check_eq("fm_req.valid", fm_req.valid, e_fm.valid);
      check_eq("fm_req.opcode", fm_req.opcode, e_fm.opcode);
      check_eq("fm_req.tq_id", fm_req.tq_id, e_fm.tq_id);
      check_eq("fm_req.address", fm_req.address, e_fm.address);
      check_eq("fm_req.data", fm_req.data, e_fm.data);
      check_eq("victim_way", i_cache_pipe.bus_q3.victim_way, e_vic);
    end
  endtask

  task automatic run_one(input cache_lu_pkg::lu_op_t op, input cache_lu_pkg::addr_t addr,
                         input cache_lu_pkg::word_t word, input cache_lu_pkg::cl_data_t line);
    issue(op, addr, word, line, 1'b0);
    idle();
    drain();
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic test_read_miss();
    run_one(cache_lu_pkg::lu_rd, 20'h0a110, '0, '0);  // empty cache, fill request out
  endtask

  task automatic test_fill_then_read();
    run_one(cache_lu_pkg::lu_fill, 20'h0a110, '0, rand_line());
    run_one(cache_lu_pkg::lu_rd, 20'h0a114, '0, '0);
  endtask

  task automatic test_write_merge();
    run_one(cache_lu_pkg::lu_wr, 20'h0a118, $random(seed), '0);  // word 2 only
    run_one(cache_lu_pkg::lu_rd, 20'h0a110, '0, '0);
  endtask

  // way 0 written before the mru flip, so the fifth fill evicts it dirty
  // way 1 comes in already dirty and leaves with the sixth fill
  task automatic test_victim_evict();
    run_one(cache_lu_pkg::lu_fill, 20'h10050, '0, rand_line());
    run_one(cache_lu_pkg::lu_wr, 20'h10054, $random(seed), '0);
    issue(cache_lu_pkg::lu_fill, 20'h11050, '0, rand_line(), 1'b1);
    idle();
    drain();
    run_one(cache_lu_pkg::lu_fill, 20'h12050, '0, rand_line());
    run_one(cache_lu_pkg::lu_fill, 20'h13050, '0, rand_line());
    run_one(cache_lu_pkg::lu_fill, 20'h14050, '0, rand_line());
    run_one(cache_lu_pkg::lu_fill, 20'h15050, '0, rand_line());
  endtask

  task automatic test_back_to_back();
    issue(cache_lu_pkg::lu_fill, 20'h3c290, '0, rand_line(), 1'b0);
    issue(cache_lu_pkg::lu_rd, 20'h3c290, '0, '0, 1'b0);         // tag bypass
    idle();
    drain();
    issue(cache_lu_pkg::lu_wr, 20'h3c294, $random(seed), '0, 1'b0);
    issue(cache_lu_pkg::lu_rd, 20'h3c290, '0, '0, 1'b0);         // data bypass
    idle();
    drain();
  endtask

  initial begin
    rst    = 1'b1;
    lu_req = '0;
    seed   = 32'h547b;
    tq_cnt = '0;
    for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_mru[s]   = '0;
      m_mod[s]   = '0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    test_read_miss();
    test_fill_then_read();
    test_write_merge();
    test_victim_evict();
    test_back_to_back();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* cache_rsp_stage.sv */
/* q3 response stage
   lookup response, far-memory fill request or dirty evict,
   and the data array write with word merge */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_rsp_stage (
  input  cache_array_pkg::pipe_bus_t  bus_in,
  input  cache_lu_pkg::cl_data_t      cl_rd_data,
  output cache_lu_pkg::lu_rsp_t       lu_rsp,
  output cache_lu_pkg::fm_req_t       fm_req,
  output cache_array_pkg::cl_wr_req_t cl_wr_req
);

  logic                            is_rd;
  logic                            is_wr;
  logic                            is_fill;
  logic [`CACHE_WORD_OFF_W-1:0]    word_off;
  cache_lu_pkg::cl_data_t          merged;  // array line with the write word in
  cache_lu_pkg::addr_t             lu_addr;

  assign is_rd    = bus_in.valid && (bus_in.lu_op == cache_lu_pkg::lu_rd);
  assign is_wr    = bus_in.valid && (bus_in.lu_op == cache_lu_pkg::lu_wr);
  assign is_fill  = bus_in.valid && (bus_in.lu_op == cache_lu_pkg::lu_fill);
  assign word_off = bus_in.offset[`CACHE_WORD_OFF_LSB +: `CACHE_WORD_OFF_W];
  assign lu_addr  = {bus_in.tag, bus_in.set, bus_in.offset};

  // ==============================
  // lookup response
  // ==============================
  assign lu_rsp.valid   = bus_in.valid;
  assign lu_rsp.lu_op   = bus_in.lu_op;
  assign lu_rsp.result  = bus_in.hit  ? cache_lu_pkg::res_hit  :
                          bus_in.miss ? cache_lu_pkg::res_miss :
                                        cache_lu_pkg::res_no_rsp;
  assign lu_rsp.tq_id   = bus_in.tq_id;
  assign lu_rsp.address = lu_addr;
  assign lu_rsp.data    = is_fill              ? bus_in.cl_data :
                          (is_rd && bus_in.hit) ? cl_rd_data    : '0;

  // ==============================
  // far memory
  // ==============================
  always_comb begin
    fm_req = '0;
    if (bus_in.miss && !is_fill) begin            // rd or wr miss
      fm_req.valid   = 1'b1;
      fm_req.opcode  = cache_lu_pkg::fm_fill_req;
      fm_req.tq_id   = bus_in.tq_id;
      fm_req.address = lu_addr;
    end
    if (is_fill && bus_in.dirty_evict) begin
      fm_req.valid   = 1'b1;
      fm_req.opcode  = cache_lu_pkg::fm_dirty_evict;
      fm_req.tq_id   = bus_in.tq_id;
      fm_req.address = {bus_in.victim_tag, bus_in.set, {`CACHE_OFFSET_W{1'b0}}};
      fm_req.data    = cl_rd_data;                // victim line read at q2
    end
  end

  // ==============================
  // data array write
  // ==============================
  always_comb begin
    merged           = cl_rd_data;
    merged[word_off] = bus_in.data;
  end

  assign cl_wr_req.en      = (is_wr && bus_in.hit) || is_fill;
  assign cl_wr_req.cl_addr = bus_in.cl_addr;
  assign cl_wr_req.data    = is_fill ? bus_in.cl_data : merged;

endmodule

/* cache_tag_array.sv */
/* cache tag array
   per-set tags with valid, mru and modified bits
   registered read, a same-cycle write to the read set is forwarded */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tag_array (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`CACHE_SET_W-1:0]      rd_set,
  output cache_array_pkg::set_rd_rsp_t rd_rsp,
  input  cache_array_pkg::set_wr_req_t wr_req
);

  cache_array_pkg::way_tags_t tag_mem  [`CACHE_NUM_SETS]; // plain storage
  cache_array_pkg::way_vec_t  valid_q  [`CACHE_NUM_SETS];
  cache_array_pkg::way_vec_t  mru_q    [`CACHE_NUM_SETS];
  cache_array_pkg::way_vec_t  mod_q    [`CACHE_NUM_SETS];
  logic                       bypass;

  assign bypass = wr_req.en && (wr_req.set == rd_set); // q2 update hits the q1 set

  always_ff @(posedge clk) begin
    if (wr_req.en) begin
      tag_mem[wr_req.set] <= wr_req.payload.tags;
    end
  end

  // state bits, all clear out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
        valid_q[s] <= '0;
        mru_q[s]   <= '0;
        mod_q[s]   <= '0;
      end
    end else if (wr_req.en) begin
      valid_q[wr_req.set] <= wr_req.payload.valid;
      mru_q[wr_req.set]   <= wr_req.payload.mru;
      mod_q[wr_req.set]   <= wr_req.payload.modified;
    end
  end

  always_ff @(posedge clk) begin
    if (bypass) begin
      rd_rsp <= wr_req.payload;        // newest state wins
    end else begin
      rd_rsp.tags     <= tag_mem[rd_set];
      rd_rsp.valid    <= valid_q[rd_set];
      rd_rsp.mru      <= mru_q[rd_set];
      rd_rsp.modified <= mod_q[rd_set];
    end
  end

endmodule

/* cache_tag_stage.sv */
/* q2 tag stage
   tag compare, victim choice for fills, new set state for the tag array
   and the data array read address */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tag_stage (
  input  cache_array_pkg::pipe_bus_t   bus_in,
  input  cache_array_pkg::set_rd_rsp_t set_rsp,
  output cache_array_pkg::pipe_bus_t   bus_out,
  output cache_array_pkg::set_wr_req_t set_wr,
  output cache_array_pkg::cl_addr_t    cl_rd_addr
);

  cache_array_pkg::way_vec_t    hit_way;
  cache_array_pkg::way_vec_t    victim_way;
  cache_array_pkg::way_vec_t    access_way;  // way touched by this lookup
  cache_array_pkg::way_t        hit_idx;
  cache_array_pkg::way_t        victim_idx;
  cache_array_pkg::set_rd_rsp_t new_set;
  logic                         hit;
  logic                         is_fill;
  logic                         is_wr;

  // lowest set bit of a way vector
  function automatic cache_array_pkg::way_vec_t first_one(cache_array_pkg::way_vec_t vec);
    return vec & (~vec + 1'b1);
  endfunction

  // one-hot to way number
  function automatic cache_array_pkg::way_t way_idx(cache_array_pkg::way_vec_t onehot);
    cache_array_pkg::way_t idx;
    idx = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (onehot[w]) idx = `CACHE_WAY_W'(w);
    end
    return idx;
  endfunction

  assign is_fill = bus_in.valid && (bus_in.lu_op == cache_lu_pkg::lu_fill);
  assign is_wr   = bus_in.valid && (bus_in.lu_op == cache_lu_pkg::lu_wr);

  // ==============================
  // tag compare and victim
  // ==============================
  always_comb begin
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      hit_way[w] = bus_in.valid && set_rsp.valid[w] && (set_rsp.tags[w] == bus_in.tag);
    end
    hit = |hit_way;
    victim_way = '0;
    if (is_fill) begin
      victim_way = (~set_rsp.valid != '0) ? first_one(~set_rsp.valid) // free way first
                                          : first_one(~set_rsp.mru);  // else first non-mru
    end
  end

  assign hit_idx    = way_idx(hit_way);
  assign victim_idx = way_idx(victim_way);
  assign access_way = hit ? hit_way : victim_way;

  // ==============================
  // new set state
  // ==============================
  always_comb begin
    new_set = set_rsp;                            // untouched by default
    if (hit) begin
      new_set.mru = set_rsp.mru | hit_way;
      if (is_wr) new_set.modified = set_rsp.modified | hit_way;
    end
    if (is_fill) begin
      new_set.tags[victim_idx]     = bus_in.tag;
      new_set.valid                = set_rsp.valid | victim_way;
      new_set.mru                  = set_rsp.mru | victim_way;
      new_set.modified[victim_idx] = bus_in.fill_modified;
    end
    if (&new_set.mru) new_set.mru = access_way;   // bit flip, keep only the newest
  end

  assign set_wr.en      = bus_in.valid;
  assign set_wr.set     = bus_in.set;
  assign set_wr.payload = new_set;

  assign cl_rd_addr.set = bus_in.set;
  assign cl_rd_addr.way = is_fill ? victim_idx : hit_idx; // victim line feeds an evict

  always_comb begin
    bus_out             = bus_in;
    bus_out.hit         = hit;
    bus_out.miss        = bus_in.valid && !hit;
    bus_out.hit_way     = hit_way;
    bus_out.victim_way  = victim_way;
    bus_out.cl_addr     = cl_rd_addr;
    bus_out.dirty_evict = |(victim_way & set_rsp.valid & set_rsp.modified);
    bus_out.victim_tag  = set_rsp.tags[victim_idx]; // old tag, before the fill
  end

endmodule

/* list.f */
+incdir+.
cache_lu_pkg.sv
cache_array_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_tag_stage.sv
cache_rsp_stage.sv
cache_pipe.sv
cache_pipe_assert.sv
cache_pipe_tb.sv
